// File: include/stream_routing_macros.svh
// Sizing for the acquisition routing subsystem.
// Include this wherever a data width, channel count or frame length is needed.
// The header word packs a channel number and a sequence number into one data word.

`ifndef STREAM_ROUTING_MACROS_SVH
`define STREAM_ROUTING_MACROS_SVH

// Width of one beat's data word
`define STREAM_DATA_WIDTH 16

// Framers feeding the selector, one per acquisition channel
`define STREAM_CHANNELS 8

// Sample beats that follow each header beat
`define FRAME_LENGTH 4

`endif

// File: src/acquisition_pkg.sv
// Types that describe acquisition channels and the frames they produce.
// Used by the framers, the frame decoder and the beat word definition.

`include "stream_routing_macros.svh"

package acquisition_pkg;

    // Channel number, wide enough to address every framer
    typedef logic [$clog2(`STREAM_CHANNELS)-1:0] channel_t;

    // Frame sequence number takes whatever the channel leaves of a data word and wraps
    typedef logic [`STREAM_DATA_WIDTH-$clog2(`STREAM_CHANNELS)-1:0] sequence_t;

    // One report per completed frame, done is a single-cycle strobe
    typedef struct packed {
        logic      done;
        channel_t  channel;
        sequence_t seq_number;
        logic      error;
    } frame_status_t;

endpackage

// File: src/stream_pkg.sv
// Stream beat format shared by the framers, the selector and the decoder.
// The user bit tells which view of the data word is valid.

`include "stream_routing_macros.svh"

package stream_pkg;

    // Header fields, channel in the upper bits
    typedef struct packed {
        acquisition_pkg::channel_t  channel;
        acquisition_pkg::sequence_t seq_number;
    } header_word_t;

    // One data word seen either as a signed sample or as a frame header
    typedef union packed {
        logic signed [`STREAM_DATA_WIDTH-1:0] sample;
        header_word_t                         header;
    } beat_word_u;

    // A beat moves when valid and the receiver's ready are both high
    // user set marks a header beat
    typedef struct packed {
        logic       valid;
        logic       tlast;
        logic       user;
        beat_word_u data;
    } stream_beat_t;

endpackage

// File: src/channel_framer.sv
// Frames one acquisition channel's sample strobes into stream beats.
// Each frame is a header beat with channel and sequence number, then FRAME_LENGTH
// samples with tlast on the last one. A two-entry buffer absorbs short stalls and
// strobes that find it full are dropped and flagged in the sticky overflow bit.

`timescale 1ns/10ps
`include "stream_routing_macros.svh"

module channel_framer #(
    parameter acquisition_pkg::channel_t CHANNEL = '0
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 sample_strobe,
    input  logic signed [`STREAM_DATA_WIDTH-1:0] sample,
    output stream_pkg::stream_beat_t             beat,
    input  logic                                 ready,
    output logic                                 overflow
);
    import acquisition_pkg::*;
    import stream_pkg::*;

    localparam int COUNT_WIDTH = $clog2(`FRAME_LENGTH + 1);

    // A buffered sample remembers where it sits in its frame
    typedef struct packed {
        logic                                 first;
        logic                                 last;
        logic signed [`STREAM_DATA_WIDTH-1:0] value;
    } entry_t;

    entry_t                 entries [0:1];
    entry_t                 head;
    logic                   write_pointer;
    logic                   read_pointer;
    logic [1:0]             fill;
    logic [COUNT_WIDTH-1:0] sample_count;
    sequence_t              seq_number;
    logic                   header_sent;
    logic                   send_header;
    logic                   push;
    logic                   pop;
    logic                   transfer;
    beat_word_u             word;

    assign head        = entries[read_pointer];
    assign send_header = head.first && !header_sent;
    assign transfer    = beat.valid && ready;
    // The header beat goes out without consuming the buffered first sample
    assign pop         = transfer && !send_header;
    assign push        = sample_strobe && (fill != 2'd2);

    always_comb begin
        if (send_header) begin
            word.header.channel    = CHANNEL;
            word.header.seq_number = seq_number;
        end else begin
            word.sample = head.value;
        end
        beat.valid = (fill != 2'd0);
        beat.tlast = !send_header && head.last;
        beat.user  = send_header;
        beat.data  = word;
    end

    always_ff @(posedge clock) begin
        if (push) begin
            entries[write_pointer].first <= (sample_count == '0);
            entries[write_pointer].last  <= (sample_count == COUNT_WIDTH'(`FRAME_LENGTH - 1));
            entries[write_pointer].value <= sample;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            write_pointer <= 1'b0;
            read_pointer  <= 1'b0;
            fill          <= 2'd0;
            sample_count  <= '0;
            seq_number    <= '0;
            header_sent   <= 1'b0;
            overflow      <= 1'b0;
        end else begin
            if (push) begin
                write_pointer <= !write_pointer;
                if (sample_count == COUNT_WIDTH'(`FRAME_LENGTH - 1)) begin
                    sample_count <= '0;
                end else begin
                    sample_count <= sample_count + 1'b1;
                end
            end
            if (sample_strobe && fill == 2'd2) begin
                overflow <= 1'b1;
            end
            if (transfer && send_header) begin
                header_sent <= 1'b1;
            end
            if (pop) begin
                read_pointer <= !read_pointer;
                header_sent  <= 1'b0;
                // Next frame's header carries the following sequence number
                if (head.last) begin
                    seq_number <= seq_number + 1'b1;
                end
            end
            fill <= fill + {1'b0, push} - {1'b0, pop};
        end
    end

endmodule

// File: src/stream_mux_8.sv
// Registered stream selector, passes the addressed input to one output register.
// Input ready follows the output register's state, so a beat is never split,
// duplicated or lost when the address moves between beats.

`timescale 1ns/10ps
`include "stream_routing_macros.svh"

module stream_mux_8 (
    input  logic                          clock,
    input  logic                          reset,
    input  acquisition_pkg::channel_t     address,
    input  stream_pkg::stream_beat_t      stream_in [0:`STREAM_CHANNELS-1],
    output logic [`STREAM_CHANNELS-1:0]   stream_in_ready,
    output stream_pkg::stream_beat_t      stream_out,
    input  logic                          stream_out_ready
);
    import stream_pkg::*;

    stream_beat_t selected;
    logic         out_free;
    logic         take;

    assign selected = stream_in[address];

    // The register can load when it is empty or drains in this same cycle
    assign out_free = !stream_out.valid || stream_out_ready;
    assign take     = out_free && selected.valid;

    // Only the addressed input ever sees ready
    always_comb begin
        stream_in_ready          = '0;
        stream_in_ready[address] = out_free;
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            stream_out.valid <= 1'b0;
        end else if (take) begin
            stream_out <= selected;
        end else if (stream_out_ready) begin
            stream_out.valid <= 1'b0;
        end
    end

endmodule

// File: src/frame_decoder.sv
// Far-end frame decoder, splits header beats from sample beats.
// Reports each sample of an open frame and one status word per tlast, with error
// set when the frame length is wrong or samples came without a header.
// All outputs are registered one cycle after the beat is accepted.

`timescale 1ns/10ps
`include "stream_routing_macros.svh"

module frame_decoder (
    input  logic                                 clock,
    input  logic                                 reset,
    input  stream_pkg::stream_beat_t             beat,
    input  logic                                 sink_ready,
    output logic                                 beat_ready,
    output logic                                 sample_valid,
    output logic signed [`STREAM_DATA_WIDTH-1:0] sample,
    output acquisition_pkg::channel_t            sample_channel,
    output acquisition_pkg::frame_status_t       frame_status
);
    import acquisition_pkg::*;

    // One spare bit so a long frame does not wrap back to a legal count
    localparam int COUNT_WIDTH = $clog2(`FRAME_LENGTH + 1) + 1;

    logic                   accept;
    logic                   is_header;
    logic                   frame_open;
    logic                   pending_error;
    logic                   count_ok;
    logic [COUNT_WIDTH-1:0] sample_count;
    channel_t               open_channel;
    sequence_t              open_seq;

    // The sink alone decides back-pressure
    assign beat_ready = sink_ready;
    assign accept     = beat.valid && sink_ready;
    assign is_header  = beat.user;
    assign count_ok   = (sample_count + 1'b1) == COUNT_WIDTH'(`FRAME_LENGTH);

    always_ff @(posedge clock) begin
        if (!reset) begin
            frame_open        <= 1'b0;
            pending_error     <= 1'b0;
            sample_count      <= '0;
            sample_valid      <= 1'b0;
            frame_status.done <= 1'b0;
        end else begin
            sample_valid      <= 1'b0;
            frame_status.done <= 1'b0;
            if (accept && is_header) begin
                frame_open   <= 1'b1;
                sample_count <= '0;
            end else if (accept) begin
                if (frame_open) begin
                    sample_valid <= 1'b1;
                    sample_count <= sample_count + 1'b1;
                end else begin
                    // Orphan sample, held over to mark the next report
                    pending_error <= 1'b1;
                end
                if (beat.tlast) begin
                    frame_status.done       <= 1'b1;
                    frame_status.channel    <= open_channel;
                    frame_status.seq_number <= open_seq;
                    frame_status.error      <= !frame_open || pending_error || !count_ok;
                    frame_open              <= 1'b0;
                    pending_error           <= 1'b0;
                    sample_count            <= '0;
                end
            end
        end
    end

    // Header fields and sample payload, read through the view the user bit selects
    always_ff @(posedge clock) begin
        if (accept && is_header) begin
            open_channel <= beat.data.header.channel;
            open_seq     <= beat.data.header.seq_number;
        end
        if (accept && !is_header) begin
            sample         <= beat.data.sample;
            sample_channel <= open_channel;
        end
    end

endmodule

// File: src/stream_routing_top.sv
// Top level of the routing subsystem: one framer per channel, the address
// driven selector and the far-end frame decoder.
// A strobe on the selected idle channel reaches the decoder two cycles later.

`timescale 1ns/10ps
`include "stream_routing_macros.svh"

module stream_routing_top (
    input  logic                                 clock,
    input  logic                                 reset,
    input  acquisition_pkg::channel_t            address,
    input  logic [`STREAM_CHANNELS-1:0]          sample_strobe,
    input  logic signed [`STREAM_DATA_WIDTH-1:0] samples [0:`STREAM_CHANNELS-1],
    input  logic                                 sink_ready,
    output logic                                 sample_valid,
    output logic signed [`STREAM_DATA_WIDTH-1:0] sample,
    output acquisition_pkg::channel_t            sample_channel,
    output acquisition_pkg::frame_status_t       frame_status,
    output logic [`STREAM_CHANNELS-1:0]          overflow
);
    import acquisition_pkg::*;
    import stream_pkg::*;

    stream_beat_t                framed [0:`STREAM_CHANNELS-1];
    logic [`STREAM_CHANNELS-1:0] framed_ready;
    stream_beat_t                routed;
    logic                        routed_ready;

    // Each framer stamps its own index into its headers
    for (genvar ch = 0; ch < `STREAM_CHANNELS; ch++) begin : g_framer
        channel_framer #(
            .CHANNEL (channel_t'(ch))
        ) u_framer (
            .clock         (clock),
            .reset         (reset),
            .sample_strobe (sample_strobe[ch]),
            .sample        (samples[ch]),
            .beat          (framed[ch]),
            .ready         (framed_ready[ch]),
            .overflow      (overflow[ch])
        );
    end

    stream_mux_8 u_mux (
        .clock            (clock),
        .reset            (reset),
        .address          (address),
        .stream_in        (framed),
        .stream_in_ready  (framed_ready),
        .stream_out       (routed),
        .stream_out_ready (routed_ready)
    );

    frame_decoder u_decoder (
        .clock          (clock),
        .reset          (reset),
        .beat           (routed),
        .sink_ready     (sink_ready),
        .beat_ready     (routed_ready),
        .sample_valid   (sample_valid),
        .sample         (sample),
        .sample_channel (sample_channel),
        .frame_status   (frame_status)
    );

endmodule

// File: bench/stream_routing_checker.sv
// Scoreboard for the routing testbench, compares decoder outputs with queued
// expected samples and frame reports and keeps the error counts.

`timescale 1ns/10ps
`include "stream_routing_macros.svh"

module stream_routing_checker (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 sample_valid,
    input  logic signed [`STREAM_DATA_WIDTH-1:0] sample,
    input  acquisition_pkg::channel_t            sample_channel,
    input  acquisition_pkg::frame_status_t       frame_status,
    input  logic [`STREAM_CHANNELS-1:0]          overflow
);
    import acquisition_pkg::*;

    // Expected sample is {channel, value}, expected report is {channel, sequence, error}
    logic [$bits(channel_t)+`STREAM_DATA_WIDTH-1:0]          sample_q [$];
    logic [$bits(channel_t)+$bits(sequence_t):0]             status_q [$];
    int error_count;
    int test_errors;
    int check_count;

    initial begin
        error_count = 0;
        test_errors = 0;
        check_count = 0;
    end

    task automatic expect_sample(input channel_t ch, input logic signed [15:0] value);
        sample_q.push_back({ch, value});
    endtask

    task automatic expect_frame(input channel_t ch, input sequence_t seq, input logic err);
        status_q.push_back({ch, seq, err});
    endtask

    function automatic int outstanding();
        return sample_q.size() + status_q.size();
    endfunction

    task automatic record_error();
        error_count++;
        test_errors++;
    endtask

    task automatic check_overflow(input logic [`STREAM_CHANNELS-1:0] expected);
        check_count++;
        if (overflow !== expected) begin
            $display("Fail overflow expected %h actual %h", expected, overflow);
            record_error();
        end
    endtask

    task automatic end_test(input int id);
        if (outstanding() != 0) begin
            $display("test %0d: %0d expected reports never arrived", id, outstanding());
            record_error();
            sample_q.delete();
            status_q.delete();
        end
        if (test_errors == 0) begin
            $display("test %0d: passed", id);
        end else begin
            $display("test %0d: failed with %0d errors", id, test_errors);
        end
        test_errors = 0;
    endtask

    // Outputs change on the rising edge, so they are read in the middle of the cycle
    always @(negedge clock) begin
        logic [$bits(channel_t)+`STREAM_DATA_WIDTH-1:0] exp_sample;
        logic [$bits(channel_t)+$bits(sequence_t):0]    exp_status;
        if (reset && sample_valid) begin
            check_count++;
            if (sample_q.size() == 0) begin
                $display("unexpected sample report on channel %0d", sample_channel);
                record_error();
            end else begin
                exp_sample = sample_q.pop_front();
                if ({sample_channel, sample} !== exp_sample) begin
                    $display("Fail sample expected %h actual %h", exp_sample,
                             {sample_channel, sample});
                    record_error();
                end
            end
        end
        if (reset && frame_status.done) begin
            check_count++;
            if (status_q.size() == 0) begin
                $display("unexpected frame report for channel %0d", frame_status.channel);
                record_error();
            end else begin
                exp_status = status_q.pop_front();
                if (frame_status[$bits(exp_status)-1:0] !== exp_status) begin
                    $display("Fail frame_status expected %h actual %h", exp_status,
                             frame_status[$bits(exp_status)-1:0]);
                    record_error();
                end
            end
        end
    end

endmodule

// File: bench/stream_routing_assertions.sv
// Protocol checks bound into the selector and the decoder.
// Ports a given instance does not use are tied off in its bind.

`timescale 1ns/10ps
`include "stream_routing_macros.svh"

module stream_routing_assertions (
    input logic                        clock,
    input logic                        reset,
    input logic                        hold_valid,
    input logic                        hold_ready,
    input stream_pkg::stream_beat_t    hold_beat,
    input logic [`STREAM_CHANNELS-1:0] select_ready,
    input logic                        header_accept,
    input logic                        sample_valid,
    input logic                        frame_done
);

    // A beat waiting on the output register must not change
    stalled_beat_stable: assert property (@(posedge clock) disable iff (!reset)
        hold_valid && !hold_ready |=> $stable(hold_beat))
        else $error("stalled output beat changed");

    one_ready_at_most: assert property (@(posedge clock) disable iff (!reset)
        $onehot0(select_ready))
        else $error("more than one selector input ready");

    // Header beats produce no sample or frame report
    header_is_silent: assert property (@(posedge clock) disable iff (!reset)
        header_accept |=> !sample_valid && !frame_done)
        else $error("report raised for a header beat");

endmodule

bind stream_mux_8 stream_routing_assertions mux_checks (
    .clock         (clock),
    .reset         (reset),
    .hold_valid    (stream_out.valid),
    .hold_ready    (stream_out_ready),
    .hold_beat     (stream_out),
    .select_ready  (stream_in_ready),
    .header_accept (1'b0),
    .sample_valid  (1'b0),
    .frame_done    (1'b0)
);

bind frame_decoder stream_routing_assertions decoder_checks (
    .clock         (clock),
    .reset         (reset),
    .hold_valid    (1'b0),
    .hold_ready    (1'b1),
    .hold_beat     ('0),
    .select_ready  ('0),
    .header_accept (beat.valid && sink_ready && beat.user),
    .sample_valid  (sample_valid),
    .frame_done    (frame_status.done)
);

// File: bench/stream_routing_tb.sv
// Testbench for the routing subsystem. Applies a table of rows, each selecting a
// channel and strobing samples, models the framing and decoding rules to predict
// the decoder's reports, and hands them to the checker.

`timescale 1ns/10ps
`include "stream_routing_macros.svh"

module stream_routing_tb;
    import acquisition_pkg::*;

    localparam int ROWS = 9;
    localparam int L    = `FRAME_LENGTH;
    localparam logic [1:0] HELD = 2'd0, TOGGLE = 2'd1, LOW = 2'd2;
    // Cycles allowed for buffered beats and the last reports to arrive after the strobes
    localparam int DRAIN_LIMIT = 4 * L;

    typedef struct packed {
        channel_t   address;
        logic [7:0] mask;
        logic [4:0] count;
        logic [1:0] sink_mode;
        logic [7:0] overflow;
    } row_t;

    logic                                 clock;
    logic                                 reset;
    channel_t                             address;
    logic [`STREAM_CHANNELS-1:0]          sample_strobe;
    logic signed [`STREAM_DATA_WIDTH-1:0] samples [0:`STREAM_CHANNELS-1];
    logic                                 sink_ready;
    logic                                 sample_valid;
    logic signed [`STREAM_DATA_WIDTH-1:0] sample;
    channel_t                             sample_channel;
    frame_status_t                        frame_status;
    logic [`STREAM_CHANNELS-1:0]          overflow;

    row_t                    rows [0:ROWS-1];
    logic signed [15:0]      stim [0:7][0:15];
    logic signed [15:0]      pend_val [0:7][0:1];
    int                      pend_pos [0:7][0:1];
    int                      pend_seq [0:7][0:1];
    int                      pend_cnt [0:7];
    int                      push_pos [0:7];
    int                      push_seq [0:7];
    logic                    dec_open;
    logic                    dec_err;
    int                      dec_count;
    channel_t                dec_ch;
    sequence_t               dec_seq;
    int                      cycle_count;
    int                      cycle_limit;

    stream_routing_top dut (.*);

    stream_routing_checker scoreboard (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("run stopped after %0d cycles without finishing", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    // A header opens a frame in the model and the tlast sample closes and reports it
    task automatic decode_beat(input logic header, input logic tlast, input channel_t ch,
                               input sequence_t seq, input logic signed [15:0] value);
        if (header) begin
            dec_open  = 1'b1;
            dec_count = 0;
            dec_ch    = ch;
            dec_seq   = seq;
        end else begin
            if (dec_open) begin
                scoreboard.expect_sample(dec_ch, value);
                dec_count++;
            end else begin
                dec_err = 1'b1;
            end
            if (tlast) begin
                scoreboard.expect_frame(dec_ch, dec_seq,
                                        !dec_open || dec_err || dec_count != L);
                dec_open  = 1'b0;
                dec_err   = 1'b0;
                dec_count = 0;
            end
        end
    endtask

    // A framed sample, preceded by its header when it opens a frame
    task automatic emit_entry(input int ch, input int pos, input int seq,
                              input logic signed [15:0] value);
        if (pos == 0) begin
            decode_beat(1'b1, 1'b0, channel_t'(ch), sequence_t'(seq), '0);
        end
        decode_beat(1'b0, pos == L - 1, channel_t'(ch), '0, value);
    endtask

    task automatic flush_channel(input int ch);
        for (int i = 0; i < pend_cnt[ch]; i++) begin
            emit_entry(ch, pend_pos[ch][i], pend_seq[ch][i], pend_val[ch][i]);
        end
        pend_cnt[ch] = 0;
    endtask

    // Predicts which strobes are kept and the order their beats reach the decoder
    task automatic model_row(input row_t r);
        logic flowing;
        if (r.sink_mode != LOW) begin
            flush_channel(r.address);
        end
        for (int k = 0; k < r.count; k++) begin
            for (int ch = 0; ch < 8; ch++) begin
                stim[ch][k] = 16'($urandom);
                flowing = (ch == r.address) && (r.sink_mode != LOW);
                if (r.mask[ch] && (flowing || pend_cnt[ch] < 2)) begin
                    if (flowing) begin
                        emit_entry(ch, push_pos[ch], push_seq[ch], stim[ch][k]);
                    end else begin
                        pend_val[ch][pend_cnt[ch]] = stim[ch][k];
                        pend_pos[ch][pend_cnt[ch]] = push_pos[ch];
                        pend_seq[ch][pend_cnt[ch]] = push_seq[ch];
                        pend_cnt[ch]++;
                    end
                    if (push_pos[ch] == L - 1) begin
                        push_pos[ch] = 0;
                        push_seq[ch]++;
                    end else begin
                        push_pos[ch]++;
                    end
                end
            end
        end
        if (r.sink_mode == LOW) begin
            flush_channel(r.address);
        end
    endtask

    task automatic drive_sink(input logic [1:0] mode);
        sink_ready = (mode == HELD) || (mode == TOGGLE && cycle_count[0]);
    endtask

    task automatic run_row(input row_t r);
        int drain;
        @(negedge clock);
        address = r.address;
        // Let a newly selected channel drain what it already holds
        repeat (3) begin
            drive_sink(r.sink_mode);
            @(negedge clock);
        end
        for (int k = 0; k < r.count; k++) begin
            for (int phase = 0; phase < 4; phase++) begin
                drive_sink(r.sink_mode);
                sample_strobe = (phase == 0) ? r.mask : '0;
                for (int ch = 0; ch < 8; ch++) begin
                    samples[ch] = stim[ch][k];
                end
                @(negedge clock);
            end
        end
        sample_strobe = '0;
        sink_ready    = 1'b1;
        drain         = 0;
        while (scoreboard.outstanding() != 0 && drain < DRAIN_LIMIT) begin
            @(negedge clock);
            drain++;
        end
        repeat (3) @(negedge clock);
        scoreboard.check_overflow(r.overflow);
    endtask

    initial begin
        void'($urandom(32'h9027_f005));
        reset         = 1'b0;
        address       = '0;
        sample_strobe = '0;
        sink_ready    = 1'b1;
        cycle_count   = 0;
        for (int ch = 0; ch < 8; ch++) begin
            samples[ch]  = '0;
            pend_cnt[ch] = 0;
            push_pos[ch] = 0;
            push_seq[ch] = 0;
        end
        dec_open  = 1'b0;
        dec_err   = 1'b0;
        dec_count = 0;
        dec_ch    = '0;
        dec_seq   = '0;
        rows[0] = '{3'd0, 8'h01, 5'd4, HELD,   8'h00};
        rows[1] = '{3'd0, 8'h01, 5'd8, HELD,   8'h00};
        rows[2] = '{3'd1, 8'h02, 5'd4, HELD,   8'h00};
        rows[3] = '{3'd2, 8'h0c, 5'd2, HELD,   8'h00};
        rows[4] = '{3'd3, 8'h0c, 5'd2, HELD,   8'h00};
        rows[5] = '{3'd2, 8'h04, 5'd4, HELD,   8'h00};
        rows[6] = '{3'd4, 8'h10, 5'd8, TOGGLE, 8'h00};
        rows[7] = '{3'd5, 8'h20, 5'd5, LOW,    8'h20};
        rows[8] = '{3'd6, 8'h40, 5'd4, HELD,   8'h20};
        cycle_limit = 0;
        for (int i = 0; i < ROWS; i++) begin
            cycle_limit += int'(rows[i].count) * 4 + 3;
        end
        cycle_limit = cycle_limit * 4 + 200;
        repeat (5) @(negedge clock);
        reset = 1'b1;
        for (int i = 0; i < ROWS; i++) begin
            model_row(rows[i]);
            run_row(rows[i]);
            scoreboard.end_test(i);
        end
        $display("%0d tests, %0d checks, %0d errors", ROWS, scoreboard.check_count,
                 scoreboard.error_count);
        if (scoreboard.error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: stream_routing.f
+incdir+include
src/acquisition_pkg.sv
src/stream_pkg.sv
src/channel_framer.sv
src/stream_mux_8.sv
src/frame_decoder.sv
src/stream_routing_top.sv
bench/stream_routing_checker.sv
bench/stream_routing_assertions.sv
bench/stream_routing_tb.sv

// File: Bender.yml
package:
  name: stream_routing

export_include_dirs:
  - include

sources:
  - files:
      - src/acquisition_pkg.sv
      - src/stream_pkg.sv
      - src/channel_framer.sv
      - src/stream_mux_8.sv
      - src/frame_decoder.sv
      - src/stream_routing_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/stream_routing_checker.sv
      - bench/stream_routing_assertions.sv
      - bench/stream_routing_tb.sv
